/* source/icache_pkg.sv */
package icache_pkg;

	// Width of PC, instruction words and the statistics counters.
	localparam int WORD_BITS = 32;

	// Direct mapped, one word per line.
	localparam int ICACHE_SET_BITS = 6;
	localparam int ICACHE_LINES = 1 << ICACHE_SET_BITS;

	// PC bits above the set index and the byte offset.
	localparam int ICACHE_TAG_BITS = 30 - ICACHE_SET_BITS;

	// Stored line is {valid, tag, data}.
	localparam int ICACHE_ENTRY_BITS = 1 + ICACHE_TAG_BITS + WORD_BITS;

	// Field positions inside a stored line.
	localparam int ENTRY_VALID_BIT = ICACHE_ENTRY_BITS - 1;
	localparam int ENTRY_TAG_LSB = WORD_BITS;

	// First fetch address after reset.
	localparam logic [WORD_BITS-1:0] RESET_PC = '0;

	// Cache controller states.
	// Clearing walks every line to invalid after reset,
	// refilling waits for the bus and then for the new line to be read back.
	typedef enum logic [1:0] {
		state_clearing,
		state_idle,
		state_refilling
	} refill_state_t;

endpackage

/* source/icache_bram.sv */
`timescale 1ns/1ps

module icache_bram
	import icache_pkg::*;
(
	input wire i_clock,

	// Read port.
	input wire [ICACHE_SET_BITS-1:0] i_rd_set,
	output logic [ICACHE_ENTRY_BITS-1:0] o_rd_entry,

	// Write port.
	input wire i_wr_request,
	input wire [ICACHE_SET_BITS-1:0] i_wr_set,
	input wire [ICACHE_ENTRY_BITS-1:0] i_wr_entry
);

	// One entry per cache line.
	logic [ICACHE_ENTRY_BITS-1:0] lines [ICACHE_LINES];

	// Write lands at the edge.
	always_ff @(posedge i_clock) begin
		if (i_wr_request) begin
			lines[i_wr_set] <= i_wr_entry;
		end
	end

	// Registered read, data valid one cycle after the set.
	// A read of the set being written sees the old entry.
	always_ff @(posedge i_clock) begin
		o_rd_entry <= lines[i_rd_set];
	end

endmodule

/* source/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Redirect strobe from the branch unit.
	input wire i_redirect,
	input wire [WORD_BITS-1:0] i_redirect_pc,

	// Consumer back-pressure.
	input wire i_hold,

	// Lookup result for the current PC.
	input wire i_cache_hit,

	output logic [WORD_BITS-1:0] o_fetch_pc,
	output logic o_fetch_take
);

	logic [WORD_BITS-1:0] fetch_pc;

	// An instruction leaves only on a hit that is neither held nor
	// overridden by a redirect in the same cycle.
	assign o_fetch_take = i_cache_hit && !i_hold && !i_redirect;

	// Redirect has priority over sequential advance.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			fetch_pc <= RESET_PC;
		end else if (i_redirect) begin
			fetch_pc <= i_redirect_pc;
		end else if (o_fetch_take) begin
			fetch_pc <= fetch_pc + WORD_BITS'(4);
		end
	end

	assign o_fetch_pc = fetch_pc;

endmodule

/* source/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Fetch side.
	input wire [WORD_BITS-1:0] i_fetch_pc,
	input wire i_fetch_take,
	output logic o_hit,
	output logic [WORD_BITS-1:0] o_hit_data,

	// Refill bus.
	output logic o_bus_request,
	output logic [WORD_BITS-1:0] o_bus_address,
	input wire i_bus_ready,
	input wire [WORD_BITS-1:0] i_bus_rdata,

	// Line RAM.
	output logic [ICACHE_SET_BITS-1:0] o_ram_rd_set,
	input wire [ICACHE_ENTRY_BITS-1:0] i_ram_rdata,
	output logic o_ram_wr_request,
	output logic [ICACHE_SET_BITS-1:0] o_ram_wr_set,
	output logic [ICACHE_ENTRY_BITS-1:0] o_ram_wr_entry,

	// Statistics.
	output logic [WORD_BITS-1:0] o_hit_count,
	output logic [WORD_BITS-1:0] o_miss_count
);

	refill_state_t state;
	logic [ICACHE_SET_BITS-1:0] clear_set;

	logic [ICACHE_SET_BITS-1:0] fetch_set;
	logic [ICACHE_TAG_BITS-1:0] fetch_tag;
	logic entry_valid;
	logic [ICACHE_TAG_BITS-1:0] entry_tag;

	logic [ICACHE_SET_BITS-1:0] set_r;
	logic stale_r;
	logic line_present;
	logic tag_match;
	logic miss;

	logic refill_write;
	logic [ICACHE_SET_BITS-1:0] refill_set;
	logic [ICACHE_TAG_BITS-1:0] refill_tag;
	logic [WORD_BITS-1:0] refill_data;

	// PC split, byte offset dropped.
	assign fetch_set = i_fetch_pc[ICACHE_SET_BITS+1:2];
	assign fetch_tag = i_fetch_pc[WORD_BITS-1:ICACHE_SET_BITS+2];

	// Stored line fields.
	assign entry_valid = i_ram_rdata[ENTRY_VALID_BIT];
	assign entry_tag = i_ram_rdata[ENTRY_VALID_BIT-1:ENTRY_TAG_LSB];
	assign o_hit_data = i_ram_rdata[WORD_BITS-1:0];

	// RAM output is only meaningful when it was read for the current set
	// and no write to that set landed on the same edge.
	assign line_present = (set_r == fetch_set) && !stale_r;
	assign tag_match = entry_valid && (entry_tag == fetch_tag);

	assign o_hit = (state == state_idle) && line_present && tag_match;
	assign miss = (state == state_idle) && line_present && !tag_match;

	// Read the next set ahead when this word is taken, so straight-line
	// code streams one word per cycle.
	assign o_ram_rd_set = (o_hit && i_fetch_take) ? fetch_set + 1'b1 : fetch_set;

	// Sweep writes go straight out, refill writes come from registers.
	always_comb begin
		if (state == state_clearing) begin
			o_ram_wr_request = 1'b1;
			o_ram_wr_set = clear_set;
			o_ram_wr_entry = '0;
		end else begin
			o_ram_wr_request = refill_write;
			o_ram_wr_set = refill_set;
			o_ram_wr_entry = {1'b1, refill_tag, refill_data};
		end
	end

	// Which set the RAM is presenting, and whether it was overwritten.
	always_ff @(posedge i_clock) begin
		set_r <= o_ram_rd_set;
		stale_r <= o_ram_wr_request && (o_ram_wr_set == o_ram_rd_set);
	end

	// Controller.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= state_clearing;
			clear_set <= '0;
			o_bus_request <= 1'b0;
			refill_write <= 1'b0;
		end else begin
			refill_write <= 1'b0;
			case (state)
				state_clearing: begin
					// One line per cycle.
					clear_set <= clear_set + 1'b1;
					if (clear_set == ICACHE_SET_BITS'(ICACHE_LINES - 1)) begin
						state <= state_idle;
					end
				end
				state_idle: begin
					if (miss) begin
						state <= state_refilling;
						o_bus_request <= 1'b1;
					end
				end
				state_refilling: begin
					if (o_bus_request && i_bus_ready) begin
						o_bus_request <= 1'b0;
						refill_write <= 1'b1;
					end else if (refill_write) begin
						// Write lands on this edge; the stale flag covers the read.
						state <= state_idle;
					end
				end
				default: begin
					state <= state_clearing;
				end
			endcase
		end
	end

	// Refill address and line contents.
	always_ff @(posedge i_clock) begin
		if (miss) begin
			o_bus_address <= i_fetch_pc;
			refill_set <= fetch_set;
			refill_tag <= fetch_tag;
		end
		if (o_bus_request && i_bus_ready) begin
			refill_data <= i_bus_rdata;
		end
	end

	// Misses count at refill start, hits when the word is taken.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			if (o_hit && i_fetch_take) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (miss) begin
				o_miss_count <= o_miss_count + 1'b1;
			end
		end
	end

endmodule

/* source/fetch_output.sv */
`timescale 1ns/1ps

module fetch_output
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Accepted word from the cache.
	input wire i_take,
	input wire [WORD_BITS-1:0] i_data,
	input wire [WORD_BITS-1:0] i_pc,

	// Toward the decoder.
	output logic [WORD_BITS-1:0] o_instr,
	output logic [WORD_BITS-1:0] o_instr_pc,
	output logic o_instr_valid
);

	// Valid pulses for one cycle per taken word.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_instr_valid <= 1'b0;
		end else begin
			o_instr_valid <= i_take;
		end
	end

	// Word and PC only change on a take, so they hold
	// their last value while valid is low.
	always_ff @(posedge i_clock) begin
		if (i_take) begin
			o_instr <= i_data;
			o_instr_pc <= i_pc;
		end
	end

endmodule

/* source/icache_fetch_top.sv */
`timescale 1ns/1ps

module icache_fetch_top
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	// Fetch control.
	input wire i_redirect,
	input wire [WORD_BITS-1:0] i_redirect_pc,
	input wire i_hold,

	// Instruction output.
	output logic [WORD_BITS-1:0] o_instr,
	output logic [WORD_BITS-1:0] o_instr_pc,
	output logic o_instr_valid,

	// Refill bus.
	output logic o_bus_request,
	output logic [WORD_BITS-1:0] o_bus_address,
	input wire i_bus_ready,
	input wire [WORD_BITS-1:0] i_bus_rdata,

	// Statistics.
	output logic [WORD_BITS-1:0] o_hit_count,
	output logic [WORD_BITS-1:0] o_miss_count
);

	logic [WORD_BITS-1:0] fetch_pc;
	logic fetch_take;
	logic cache_hit;
	logic [WORD_BITS-1:0] hit_data;

	logic [ICACHE_SET_BITS-1:0] ram_rd_set;
	logic [ICACHE_ENTRY_BITS-1:0] ram_rd_entry;
	logic ram_wr_request;
	logic [ICACHE_SET_BITS-1:0] ram_wr_set;
	logic [ICACHE_ENTRY_BITS-1:0] ram_wr_entry;

	fetch_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_hold(i_hold),
		.i_cache_hit(cache_hit),
		.o_fetch_pc(fetch_pc),
		.o_fetch_take(fetch_take)
	);

	icache_lookup u_lookup (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_pc(fetch_pc),
		.i_fetch_take(fetch_take),
		.o_hit(cache_hit),
		.o_hit_data(hit_data),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_ram_rd_set(ram_rd_set),
		.i_ram_rdata(ram_rd_entry),
		.o_ram_wr_request(ram_wr_request),
		.o_ram_wr_set(ram_wr_set),
		.o_ram_wr_entry(ram_wr_entry),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	icache_bram u_bram (
		.i_clock(i_clock),
		.i_rd_set(ram_rd_set),
		.o_rd_entry(ram_rd_entry),
		.i_wr_request(ram_wr_request),
		.i_wr_set(ram_wr_set),
		.i_wr_entry(ram_wr_entry)
	);

	fetch_output u_output (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_take(fetch_take),
		.i_data(hit_data),
		.i_pc(fetch_pc),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc),
		.o_instr_valid(o_instr_valid)
	);

endmodule

/* bench/icache_checker.sv */
`timescale 1ns/1ps

module icache_checker
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_bus_request,
	input wire [WORD_BITS-1:0] i_bus_address,
	input wire i_bus_ready,
	input wire i_instr_valid
);

	int assertion_failures = 0;
	int sweep_left;

	// Lines the cache still has to clear after reset.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sweep_left <= ICACHE_LINES;
		end else if (sweep_left != 0) begin
			sweep_left <= sweep_left - 1;
		end
	end

	bus_address_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request |=> !i_bus_request || $stable(i_bus_address))
	else begin
		$error("bus address changed while the request was pending");
		assertion_failures++;
	end

	no_request_in_sweep: assert property (@(posedge i_clock) disable iff (i_reset)
		sweep_left != 0 |-> !i_bus_request)
	else begin
		$error("bus request raised during the clear sweep");
		assertion_failures++;
	end

	request_drops_after_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && i_bus_ready |=> !i_bus_request)
	else begin
		$error("bus request still high after the ready strobe");
		assertion_failures++;
	end

	// The first reset edge may still show the old valid.
	no_valid_in_reset: assert property (@(posedge i_clock)
		i_reset && $past(i_reset) |-> !i_instr_valid)
	else begin
		$error("instruction valid during reset");
		assertion_failures++;
	end

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
	import icache_pkg::*;
();

	localparam logic [WORD_BITS-1:0] DATA_PATTERN = 32'h5A3C_96E1;
	localparam int ALIAS_STRIDE = ICACHE_LINES * 4;
	// Bus latency plus request, write and reread of the line.
	localparam int MISS_WORST_CYCLES = 6 + 5;
	localparam int MISSES_EXPECTED = 64;
	localparam int TIMEOUT_CYCLES = 2 * (ICACHE_LINES + 2) +
		2 * MISSES_EXPECTED * MISS_WORST_CYCLES;

	typedef struct packed {
		logic [WORD_BITS-1:0] instr;
		logic [WORD_BITS-1:0] pc;
		logic [WORD_BITS-1:0] hits;
		logic [WORD_BITS-1:0] misses;
		int cycle;
		int requests;
	} fetch_record_t;

	logic i_clock = 1'b0;
	logic i_reset, i_redirect, i_hold;
	logic [WORD_BITS-1:0] i_redirect_pc;
	logic i_bus_ready = 1'b0;
	logic [WORD_BITS-1:0] i_bus_rdata = '0;
	logic [WORD_BITS-1:0] o_instr, o_instr_pc, o_bus_address, o_hit_count, o_miss_count;
	logic o_instr_valid, o_bus_request;

	int cycle_count = 0;
	int request_total = 0;
	logic request_seen = 1'b0;
	int bus_countdown = -1;
	fetch_record_t fetched[$];
	fetch_record_t record_now;

	bit random_latency;
	int fixed_latency;
	int first_index, release_cycle, request_base;
	int test_errors, error_count, failed_tests;

	icache_fetch_top dut (.*);

	bind icache_fetch_top icache_checker u_checker (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(o_bus_request),
		.i_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_instr_valid(o_instr_valid)
	);

	always #4 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// Bus memory: one ready strobe per request, word is address XOR pattern.
	always @(posedge i_clock) begin
		#1;
		i_bus_ready = 1'b0;
		if (i_reset || !o_bus_request) begin
			bus_countdown = -1;
		end else begin
			if (bus_countdown < 0) begin
				bus_countdown = random_latency ? int'($urandom % 6) + 1 : fixed_latency;
			end
			bus_countdown--;
			if (bus_countdown == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = o_bus_address ^ DATA_PATTERN;
			end
		end
	end

	// Output monitor, sampled mid-cycle.
	always @(negedge i_clock) begin
		if (o_bus_request === 1'b1 && !request_seen) begin
			request_total++;
		end
		request_seen = (o_bus_request === 1'b1);
		if (i_reset === 1'b0 && o_instr_valid === 1'b1) begin
			record_now.instr = o_instr;
			record_now.pc = o_instr_pc;
			record_now.hits = o_hit_count;
			record_now.misses = o_miss_count;
			record_now.cycle = cycle_count;
			record_now.requests = request_total;
			fetched.push_back(record_now);
		end
	end

	task automatic step();
		@(posedge i_clock);
		#1;
	endtask

	task automatic expect_equal(input string name, input logic [WORD_BITS-1:0] expected,
		input logic [WORD_BITS-1:0] actual);
		assert (actual === expected) else begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic expect_true(input bit condition, input string what);
		assert (condition) else begin
			$display("Error at %0t ns: %s", $time, what);
			test_errors++;
		end
	endtask

	function automatic fetch_record_t fetched_at(input int index);
		return fetched[first_index + index];
	endfunction

	task automatic wait_fetched(input int count);
		while (fetched.size() < first_index + count) begin
			step();
		end
	endtask

	task automatic expect_word(input int index, input logic [WORD_BITS-1:0] pc);
		fetch_record_t rec;
		rec = fetched_at(index);
		expect_equal("o_instr_pc", pc, rec.pc);
		expect_equal("o_instr", pc ^ DATA_PATTERN, rec.instr);
	endtask

	task automatic expect_stream(input int count, input logic [WORD_BITS-1:0] start_pc);
		for (int i = 0; i < count; i++) begin
			expect_word(i, start_pc + WORD_BITS'(4 * i));
		end
	endtask

	task automatic redirect_to(input logic [WORD_BITS-1:0] pc);
		i_redirect = 1'b1;
		i_redirect_pc = pc;
		i_hold = 1'b0;
		step();
		i_redirect = 1'b0;
	endtask

	// Hold the fetcher until any refill in flight has completed.
	task automatic park();
		i_hold = 1'b1;
		repeat (6) step();
		while (o_bus_request) begin
			step();
		end
		first_index = fetched.size();
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		i_hold = 1'b0;
		i_redirect = 1'b0;
		repeat (2) step();
		i_reset = 1'b0;
		release_cycle = cycle_count;
		first_index = fetched.size();
		request_base = request_total;
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s passed", name);
		end else begin
			$display("%s failed with %0d errors", name, test_errors);
			failed_tests++;
		end
		error_count += test_errors;
		test_errors = 0;
	endtask

	task automatic cold_sequential_fetch();
		fetch_record_t last;
		wait_fetched(16);
		last = fetched_at(15);
		expect_stream(16, RESET_PC);
		expect_equal("bus requests", 16, last.requests - request_base);
		expect_equal("o_miss_count", 16, last.misses);
		park();
		finish_test("cold_sequential_fetch");
	endtask

	task automatic warm_loop_hits();
		logic [WORD_BITS-1:0] hits_before;
		int requests_before;
		fetch_record_t last;
		fetch_record_t prev;
		fetch_record_t cur;
		hits_before = o_hit_count;
		requests_before = request_total;
		redirect_to(RESET_PC);
		wait_fetched(16);
		last = fetched_at(15);
		expect_stream(16, RESET_PC);
		expect_equal("bus requests", requests_before, last.requests);
		expect_equal("o_hit_count", hits_before + 16, last.hits);
		for (int i = 1; i < 16; i++) begin
			prev = fetched_at(i - 1);
			cur = fetched_at(i);
			expect_equal("o_instr_valid cycle", prev.cycle + 1, cur.cycle);
		end
		park();
		finish_test("warm_loop_hits");
	endtask

	task automatic aliasing_miss();
		logic [WORD_BITS-1:0] misses_before;
		fetch_record_t rec;
		misses_before = o_miss_count;
		redirect_to(RESET_PC + WORD_BITS'(ALIAS_STRIDE));
		wait_fetched(1);
		expect_word(0, RESET_PC + WORD_BITS'(ALIAS_STRIDE));
		rec = fetched_at(0);
		expect_equal("o_miss_count", misses_before + 1, rec.misses);
		park();
		// The original line was evicted by the alias.
		misses_before = o_miss_count;
		redirect_to(RESET_PC);
		wait_fetched(1);
		expect_word(0, RESET_PC);
		rec = fetched_at(0);
		expect_equal("o_miss_count", misses_before + 1, rec.misses);
		park();
		finish_test("aliasing_miss");
	endtask

	// Sets 16 to 48 only, so line 0 still holds PC 0 when reset comes.
	task automatic backpressure_random_latency();
		random_latency = 1'b1;
		redirect_to(32'h0000_2040);
		while (fetched.size() < first_index + 32) begin
			i_hold = (($urandom % 3) == 0);
			step();
		end
		i_hold = 1'b1;
		expect_stream(32, 32'h0000_2040);
		park();
		random_latency = 1'b0;
		finish_test("backpressure_random_latency");
	endtask

	task automatic reset_reinvalidates();
		fetch_record_t rec;
		apply_reset();
		expect_equal("o_hit_count", 0, o_hit_count);
		expect_equal("o_miss_count", 0, o_miss_count);
		wait_fetched(1);
		expect_word(0, RESET_PC);
		rec = fetched_at(0);
		expect_true(rec.cycle - release_cycle > ICACHE_LINES,
			"an instruction appeared before the clear sweep had finished");
		expect_equal("bus requests", 1, rec.requests - request_base);
		expect_equal("o_miss_count", 1, rec.misses);
		expect_equal("o_hit_count", 1, rec.hits);
		park();
		finish_test("reset_reinvalidates");
	endtask

	initial begin
		void'($urandom(19));
		i_reset = 1'b1;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_hold = 1'b0;
		random_latency = 1'b0;
		fixed_latency = 3;
		test_errors = 0;
		error_count = 0;
		failed_tests = 0;
		apply_reset();
		cold_sequential_fetch();
		warm_loop_hits();
		aliasing_miss();
		backpressure_random_latency();
		reset_reinvalidates();
		error_count += dut.u_checker.assertion_failures;
		$display("Tests run 5, tests failed %0d, errors %0d", failed_tests, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
source/icache_pkg.sv
source/icache_bram.sv
source/fetch_sequencer.sv
source/icache_lookup.sv
source/fetch_output.sv
source/icache_fetch_top.sv
bench/icache_checker.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "Test OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
